/* design/alu8.sv */
`timescale 1ns/1ns
`default_nettype none

module alu8
(
    input  wire cpu_pkg::byte_t   a,
    input  wire cpu_pkg::byte_t   b,
    input  wire cpu_pkg::alu_op_t op,
    input  wire logic             carry_in,
    output cpu_pkg::byte_t        result,
    output cpu_pkg::flags_t       flags_out
);
    import cpu_pkg::*;

    logic       sub_grp;
    logic       cin_eff;
    logic       cin_x;
    byte_t      b_x;
    logic [8:0] sum9;
    logic [4:0] nib5;
    logic       carry8;
    logic       half4;

    // Subtraction done as A + ~B + ~borrow
    assign sub_grp = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
    assign cin_eff = ((op == ALU_ADC) || (op == ALU_SBC)) ? carry_in : 1'b0;
    assign b_x     = sub_grp ? ~b : b;
    assign cin_x   = sub_grp ? ~cin_eff : cin_eff;

    assign sum9 = {1'b0, a} + {1'b0, b_x} + {8'd0, cin_x};
    assign nib5 = {1'b0, a[3:0]} + {1'b0, b_x[3:0]} + {4'd0, cin_x};

    // Borrow is the inverted carry
    assign carry8 = sub_grp ? ~sum9[8] : sum9[8];
    assign half4  = sub_grp ? ~nib5[4] : nib5[4];

    always_comb
    begin
        result      = sum9[7:0];
        flags_out.n = 1'b0;
        flags_out.h = half4;
        flags_out.c = carry8;
        case (op)
            ALU_SUB, ALU_SBC, ALU_CP:
            begin
                flags_out.n = 1'b1;
            end
            ALU_AND:
            begin
                result      = a & b;
                flags_out.h = 1'b1;
                flags_out.c = 1'b0;
            end
            ALU_XOR:
            begin
                result      = a ^ b;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            ALU_OR:
            begin
                result      = a | b;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            default:
            begin
                result = sum9[7:0];  // ADD, ADC
            end
        endcase
        flags_out.z = (result == 8'd0);
    end

endmodule

`default_nettype wire

/* design/bus_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_sequencer
(
    input  wire logic            clock,
    input  wire logic            arst_n,
    input  wire cpu_pkg::byte_t  inst,
    input  wire cpu_pkg::addr_t  pc,
    input  wire cpu_pkg::addr_t  addr_buf,
    input  wire cpu_pkg::byte_t  a_value,
    output cpu_pkg::fetch_ctrl_t fetch_ctrl,
    output cpu_pkg::exec_ctrl_t  exec_ctrl,
    output cpu_pkg::addr_t       db_address,
    output cpu_pkg::byte_t       db_wdata,
    output logic                 db_nread,
    output logic                 db_nwrite
);
    import cpu_pkg::*;

    seq_state_e state;
    seq_state_e state_next;
    logic       bus_active;  // Low until the first edge after reset

    logic is_alu_r;
    logic is_alu_n;
    logic is_ld_n;
    logic is_st;
    logic is_halt;
    logic fetching;
    logic reading;

    // Decode
    assign is_alu_r = (inst[7:6] == GRP_ALU_R) && (inst[2:0] != FLD_IMM);
    assign is_alu_n = (inst[7:6] == GRP_ALU_N) && (inst[2:0] == FLD_IMM);
    assign is_ld_n  = (inst[7:6] == GRP_LD_N) && (inst[2:0] == FLD_IMM)
                      && (inst[5:3] != FLD_IMM);
    assign is_st    = (inst == OPC_ST_A16);
    assign is_halt  = (inst == OPC_HALT);

    assign fetching = (state == FETCH) && bus_active;
    assign reading  = fetching || (state == OPERAND) || (state == ADDR_HI)
                      || (state == ADDR_LO);

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= FETCH;
            bus_active <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            bus_active <= 1'b1;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            FETCH:
            begin
                if (!bus_active)
                begin
                    state_next = FETCH;
                end
                else if (is_halt)
                begin
                    state_next = HALTED;
                end
                else if (is_alu_r)
                begin
                    state_next = EXECUTE;
                end
                else if (is_alu_n || is_ld_n)
                begin
                    state_next = OPERAND;
                end
                else if (is_st)
                begin
                    state_next = ADDR_HI;
                end
                else
                begin
                    state_next = FETCH;  // Unsupported opcode
                end
            end
            OPERAND: state_next = EXECUTE;
            ADDR_HI: state_next = ADDR_LO;
            ADDR_LO: state_next = WRITE;
            EXECUTE: state_next = FETCH;
            WRITE:   state_next = FETCH;
            default: state_next = HALTED;
        endcase
    end

    // Strobes to the fetch side
    assign fetch_ctrl.load_inst    = fetching;
    assign fetch_ctrl.load_operand = (state == OPERAND);
    assign fetch_ctrl.load_addr    = (state == ADDR_HI) || (state == ADDR_LO);
    assign fetch_ctrl.pc_inc       = reading;

    assign exec_ctrl.op          = inst[5:3];
    assign exec_ctrl.src         = inst[2:0];
    assign exec_ctrl.dest        = inst[5:3];
    assign exec_ctrl.use_operand = is_alu_n;
    assign exec_ctrl.alu_en      = (state == EXECUTE) && (is_alu_r || is_alu_n);
    assign exec_ctrl.load_en     = (state == EXECUTE) && is_ld_n;

    // Memory bus
    assign db_address = (state == WRITE) ? addr_buf : pc;
    assign db_wdata   = a_value;
    assign db_nread   = !reading;
    assign db_nwrite  = (state != WRITE);

endmodule

`default_nettype wire

/* design/cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core
#(
    parameter cpu_pkg::addr_t reset_pc = 16'h0000
)
(
    input  wire logic           clock,
    input  wire logic           arst_n,
    input  wire cpu_pkg::byte_t db_rdata,
    output cpu_pkg::addr_t      db_address,
    output cpu_pkg::byte_t      db_wdata,
    output logic                db_nread,
    output logic                db_nwrite,
    output cpu_pkg::flags_t     flags
);
    import cpu_pkg::*;

    fetch_ctrl_t fetch_ctrl;
    exec_ctrl_t  exec_ctrl;
    byte_t       inst;
    byte_t       operand;
    addr_t       pc;
    addr_t       addr_buf;
    byte_t       a_value;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) i_fetch_unit
    (
        .clock    (clock),
        .arst_n   (arst_n),
        .ctrl     (fetch_ctrl),
        .rdata    (db_rdata),
        .inst     (inst),
        .operand  (operand),
        .pc       (pc),
        .addr_buf (addr_buf)
    );

    exec_unit i_exec_unit
    (
        .clock   (clock),
        .arst_n  (arst_n),
        .ctrl    (exec_ctrl),
        .operand (operand),
        .a_value (a_value),
        .flags   (flags)
    );

    bus_sequencer i_bus_sequencer
    (
        .clock      (clock),
        .arst_n     (arst_n),
        .inst       (inst),
        .pc         (pc),
        .addr_buf   (addr_buf),
        .a_value    (a_value),
        .fetch_ctrl (fetch_ctrl),
        .exec_ctrl  (exec_ctrl),
        .db_address (db_address),
        .db_wdata   (db_wdata),
        .db_nread   (db_nread),
        .db_nwrite  (db_nwrite)
    );

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    // Register number as encoded in the opcode
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t REG_B = 3'd0;
    localparam reg_idx_t REG_A = 3'd7;  // Accumulator

    // ALU operation, opcode bits 5:3
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_ADC = 3'd1;
    localparam alu_op_t ALU_SUB = 3'd2;
    localparam alu_op_t ALU_SBC = 3'd3;
    localparam alu_op_t ALU_AND = 3'd4;
    localparam alu_op_t ALU_XOR = 3'd5;
    localparam alu_op_t ALU_OR  = 3'd6;
    localparam alu_op_t ALU_CP  = 3'd7;

    // Opcode fields
    localparam logic [1:0] GRP_LD_N  = 2'b00;  // Bits 7:6
    localparam logic [1:0] GRP_ALU_R = 2'b10;
    localparam logic [1:0] GRP_ALU_N = 2'b11;
    localparam logic [2:0] FLD_IMM   = 3'b110;  // Bits 2:0 for immediate forms

    localparam byte_t OPC_HALT   = 8'h76;
    localparam byte_t OPC_ST_A16 = 8'hEA;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef struct packed {
        logic load_inst;
        logic load_operand;
        logic load_addr;
        logic pc_inc;
    } fetch_ctrl_t;

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t src;
        reg_idx_t dest;
        logic     use_operand;  // B input from operand buffer
        logic     alu_en;
        logic     load_en;
    } exec_ctrl_t;

    typedef enum logic [2:0] {
        FETCH,
        OPERAND,
        ADDR_HI,
        ADDR_LO,
        EXECUTE,
        WRITE,
        HALTED
    } seq_state_e;

endpackage

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit
(
    input  wire logic                clock,
    input  wire logic                arst_n,
    input  wire cpu_pkg::exec_ctrl_t ctrl,
    input  wire cpu_pkg::byte_t      operand,
    output cpu_pkg::byte_t           a_value,
    output cpu_pkg::flags_t          flags
);
    import cpu_pkg::*;

    byte_t  regs [8];
    flags_t flag_q;

    byte_t  alu_b;
    byte_t  alu_result;
    flags_t alu_flags;

    // Second operand is either a register or the immediate byte
    assign alu_b = ctrl.use_operand ? operand : regs[ctrl.src];

    alu8 i_alu8
    (
        .a         (regs[REG_A]),
        .b         (alu_b),
        .op        (ctrl.op),
        .carry_in  (flag_q.c),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
            flag_q <= '0;
        end
        else
        begin
            if (ctrl.alu_en)
            begin
                // CP only compares
                if (ctrl.op != ALU_CP)
                begin
                    regs[REG_A] <= alu_result;
                end
                flag_q <= alu_flags;
            end
            else if (ctrl.load_en)
            begin
                regs[ctrl.dest] <= operand;
            end
        end
    end

    assign a_value = regs[REG_A];
    assign flags   = flag_q;

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
#(
    parameter cpu_pkg::addr_t reset_pc = 16'h0000
)
(
    input  wire logic                 clock,
    input  wire logic                 arst_n,
    input  wire cpu_pkg::fetch_ctrl_t ctrl,
    input  wire cpu_pkg::byte_t       rdata,
    output cpu_pkg::byte_t            inst,
    output cpu_pkg::byte_t            operand,
    output cpu_pkg::addr_t            pc,
    output cpu_pkg::addr_t            addr_buf
);
    import cpu_pkg::*;

    addr_t pc_q;
    byte_t inst_q;
    byte_t operand_q;
    addr_t addr_q;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc_q      <= reset_pc;
            inst_q    <= '0;
            operand_q <= '0;
            addr_q    <= '0;
        end
        else
        begin
            if (ctrl.pc_inc)
            begin
                pc_q <= pc_q + 16'd1;
            end

            if (ctrl.load_inst)
            begin
                inst_q <= rdata;
            end

            if (ctrl.load_operand)
            begin
                operand_q <= rdata;
            end

            // First byte loaded ends up as the high half
            if (ctrl.load_addr)
            begin
                addr_q <= {addr_q[7:0], rdata};
            end
        end
    end

    // Opcode straight from the bus while it is being fetched
    assign inst = ctrl.load_inst ? rdata : inst_q;

    assign operand  = operand_q;
    assign pc       = pc_q;
    assign addr_buf = addr_q;

endmodule

`default_nettype wire

/* dv/cpu_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;
    import cpu_pkg::*;

    localparam addr_t start_pc = 16'h0100;
    localparam int    num_rows = 23;
    localparam int    wait_max = 40;  // Cycles per wait

    typedef struct packed {
        logic     use_reg;  // ALU A,r instead of ALU A,n
        alu_op_t  op;
        byte_t    a_val;
        byte_t    b_val;
        reg_idx_t src;
        addr_t    st_addr;
        byte_t    exp_byte;
        flags_t   exp_flags;
    } row_t;

    // Fixed rows as use_reg, op, A, B
    localparam logic [19:0] fixed_rows [7] = '{
        {1'b0, ALU_SUB, 8'h5A, 8'h5A},  // Zero result
        {1'b1, ALU_ADD, 8'h0F, 8'h01},  // Half carry
        {1'b0, ALU_SUB, 8'h10, 8'h20},  // Borrow
        {1'b1, ALU_ADC, 8'hFF, 8'h00},  // Carry chain starts here
        {1'b0, ALU_SBC, 8'h00, 8'h00},
        {1'b1, ALU_ADC, 8'h01, 8'h01},
        {1'b0, ALU_SBC, 8'h05, 8'h02}
    };

    logic   clock;
    logic   arst_n;
    byte_t  db_rdata;
    addr_t  db_address;
    byte_t  db_wdata;
    logic   db_nread;
    logic   db_nwrite;
    flags_t flags;

    byte_t  mem [65536];
    row_t   rows [num_rows];
    addr_t  wr_addr_q [$];
    byte_t  wr_data_q [$];
    flags_t wr_flags_q [$];
    addr_t  prog_ptr;
    integer seed;
    int     error_count = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    cpu_core #(
        .reset_pc (start_pc)
    ) i_cpu_core
    (
        .clock      (clock),
        .arst_n     (arst_n),
        .db_rdata   (db_rdata),
        .db_address (db_address),
        .db_wdata   (db_wdata),
        .db_nread   (db_nread),
        .db_nwrite  (db_nwrite),
        .flags      (flags)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #4 clock = ~clock;
        end
    end

    // Memory answers in the same cycle
    assign db_rdata = db_nread ? 8'h00 : mem[db_address];

    always @(negedge clock)
    begin
        if (arst_n && !db_nwrite)
        begin
            wr_addr_q.push_back(db_address);
            wr_data_q.push_back(db_wdata);
            wr_flags_q.push_back(flags);  // Flags of the row just stored
        end
    end

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flags(input string what, input flags_t got, input flags_t exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s znhc=%b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before)
        begin
            pass_count++;
            $display("%s: ok", name);
        end
        else
        begin
            fail_count++;
            $display("%s: %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic put_byte(input byte_t value);
        mem[prog_ptr] = value;
        prog_ptr      = prog_ptr + 16'd1;
    endtask

    // Reference ALU from the flag rules
    function automatic byte_t model_alu(input alu_op_t op, input byte_t a, input byte_t b,
                                        input logic c_in, output flags_t f);
        int    cin;
        int    full;
        int    half;
        byte_t res;

        cin = ((op == ALU_ADC) || (op == ALU_SBC)) ? int'(c_in) : 0;
        f   = '0;
        case (op)
            ALU_ADD, ALU_ADC:
            begin
                full = int'(a) + int'(b) + cin;
                half = int'(a[3:0]) + int'(b[3:0]) + cin;
                res  = byte_t'(full);
                f.h  = (half > 15);
                f.c  = (full > 255);
            end
            ALU_AND:
            begin
                res = a & b;
                f.h = 1'b1;
            end
            ALU_XOR: res = a ^ b;
            ALU_OR:  res = a | b;
            default:
            begin
                full = int'(a) - int'(b) - cin;  // SUB, SBC, CP
                half = int'(a[3:0]) - int'(b[3:0]) - cin;
                res  = byte_t'(full);
                f.n  = 1'b1;
                f.h  = (half < 0);
                f.c  = (full < 0);
            end
        endcase
        f.z = (res == 8'd0);
        return res;
    endfunction

    initial
    begin
        int     i;
        int     t;
        int     errs;
        logic   found;
        logic   carry;
        logic   timed_out;
        byte_t  res;
        flags_t fl;

        arst_n    = 1'b0;
        seed      = 26775;
        prog_ptr  = start_pc;
        carry     = 1'b0;  // Flags are clear after reset
        timed_out = 1'b0;

        // Table, expected values and program in one pass
        for (i = 0; i < num_rows; i++)
        begin
            if (i < 16)
            begin
                rows[i].use_reg = (i >= 8);
                rows[i].op      = alu_op_t'(i % 8);
                rows[i].a_val   = byte_t'($random(seed));
                rows[i].b_val   = byte_t'($random(seed));
            end
            else
            begin
                {rows[i].use_reg, rows[i].op, rows[i].a_val, rows[i].b_val}
                    = fixed_rows[i - 16];
            end
            rows[i].src       = reg_idx_t'(i % 6);  // B through L
            rows[i].st_addr   = addr_t'(32'h9000 + i * 32'h0111);
            res               = model_alu(rows[i].op, rows[i].a_val, rows[i].b_val, carry, fl);
            rows[i].exp_byte  = (rows[i].op == ALU_CP) ? rows[i].a_val : res;
            rows[i].exp_flags = fl;
            carry             = fl.c;

            put_byte({2'b00, REG_A, 3'b110});  // LD A,n
            put_byte(rows[i].a_val);
            if (rows[i].use_reg)
            begin
                put_byte({2'b00, rows[i].src, 3'b110});
                put_byte(rows[i].b_val);
                put_byte({2'b10, rows[i].op, rows[i].src});
            end
            else
            begin
                put_byte({2'b11, rows[i].op, 3'b110});
                put_byte(rows[i].b_val);
            end
            put_byte(OPC_ST_A16);
            put_byte(rows[i].st_addr[15:8]);  // High byte first
            put_byte(rows[i].st_addr[7:0]);
        end
        put_byte(OPC_HALT);

        errs = error_count;
        repeat (3)
        begin
            @(negedge clock);
            check_level("db_nread in reset", db_nread, 1'b1);
            check_level("db_nwrite in reset", db_nwrite, 1'b1);
        end
        @(posedge clock);
        #1 arst_n = 1'b1;

        found = 1'b0;
        for (t = 0; t < wait_max && !found; t++)
        begin
            @(negedge clock);
            if (!db_nread)
            begin
                found = 1'b1;
                check_addr("first fetch address", db_address, start_pc);
            end
        end
        if (!found)
        begin
            $display("No memory read was seen after reset");
            error_count++;
            timed_out = 1'b1;
        end
        report_test("reset and first fetch", errs);

        for (i = 0; i < num_rows && !timed_out; i++)
        begin
            errs = error_count;
            for (t = 0; t < wait_max && wr_addr_q.size() <= i; t++)
            begin
                @(posedge clock);
            end
            if (wr_addr_q.size() <= i)
            begin
                $display("Row %0d stored nothing within %0d cycles", i, wait_max);
                error_count++;
                timed_out = 1'b1;
            end
            else
            begin
                check_addr($sformatf("row %0d store address", i), wr_addr_q[i],
                           rows[i].st_addr);
                check_byte($sformatf("row %0d stored byte", i), wr_data_q[i], rows[i].exp_byte);
                check_flags($sformatf("row %0d flags", i), wr_flags_q[i], rows[i].exp_flags);
            end
            report_test($sformatf("row %0d ALU %s op %0d", i,
                                  rows[i].use_reg ? "A,r" : "A,n", rows[i].op), errs);
        end

        // HALT is fetched right after the last store
        if (!timed_out)
        begin
            errs = error_count;
            @(negedge clock);
            check_level("read of HALT", db_nread, 1'b0);
            check_addr("HALT fetch address", db_address, prog_ptr - 16'd1);
            repeat (20)
            begin
                @(negedge clock);
                check_level("db_nread after HALT", db_nread, 1'b1);
                check_level("db_nwrite after HALT", db_nwrite, 1'b1);
            end
            report_test("bus idle after HALT", errs);
        end

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (error_count == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module cpu_core_tb \
    -f src.f -o cpu_core_sim || exit 1
result=$(./obj_dir/cpu_core_sim)
echo "$result"
echo "$result" | grep -qx "Simulation passed" && exit 0 || exit 1

/* src.f */
design/cpu_pkg.sv
design/alu8.sv
design/exec_unit.sv
design/fetch_unit.sv
design/bus_sequencer.sv
design/cpu_core.sv
dv/cpu_core_tb.sv
